// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
common/dma_bus_pkg.sv
common/dma_layer_pkg.sv
src/dma_ctrl.sv
src/layer_regs.sv
walker/tile_walker.sv
src/dma_top.sv
sim/clk_gen.sv
sim/ext_mem_model.sv
sim/tb_top.sv

// ==== common/dma_bus_pkg.sv ====
// Opcodes, address and data widths
// and the descriptor word count of the DMA command and memory buses
`default_nettype none

package dma_bus_pkg;

	localparam int ADDR_W = 32; // External and buffer address width
	localparam int DATA_W = 32;
	localparam int OP_W   = 3;

	// Command opcodes
	localparam logic [OP_W-1:0] OP_INIT = 3'd0; // Load layer descriptor
	localparam logic [OP_W-1:0] OP_FMI  = 3'd1; // Fetch input tile
	localparam logic [OP_W-1:0] OP_FMO  = 3'd2; // Flush output tile

	// Descriptor words read from address 0 upward
	localparam int INIT_WORDS = 4;

endpackage

`default_nettype wire

// ==== common/dma_layer_pkg.sv ====
// Layer descriptor field widths, tile size constants
// and the descriptor word union with its three decodings
`default_nettype none

package dma_layer_pkg;

	localparam int DIM_W = 8;  // Spatial dimension width
	localparam int CH_W  = 11; // Channel count width

	// Input tile size, output tile is this shifted by stride
	localparam logic [DIM_W-1:0] TILE_X = 8;
	localparam logic [DIM_W-1:0] TILE_Y = 8;

	// One descriptor word seen as dims, channels or a base address
	typedef union packed {
		struct packed {
			logic [11:0]      rsvd;
			logic             stride;  // 0 for stride 1, 1 for stride 2
			logic [2:0]       spare;   // Unused
			logic [DIM_W-1:0] niy;
			logic [DIM_W-1:0] nix;
		} dims;
		struct packed {
			logic [8:0]      rsvd;
			logic [CH_W-1:0] nof;
			logic            spare;
			logic [CH_W-1:0] nif;
		} chan;
		logic [31:0] raw;          // Feature map base address
	} layer_word_u;

endpackage

`default_nettype wire

// ==== sim/clk_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #20 clk_o = ~clk_o; // 40 ns period

endmodule

`default_nettype wire

// ==== sim/ext_mem_model.sv ====
// External memory model with a single outstanding request
// and a 0 to 3 cycle acknowledge delay drawn from a Galois LFSR
`timescale 1ns/1ps
`default_nettype none

module ext_mem_model
	import dma_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              req_i,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              pre_we_i,   // Backdoor preload port
	input  logic [11:0]       pre_addr_i,
	input  logic [DATA_W-1:0] pre_data_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] rdata_o
);

	localparam logic [31:0] SEED = 32'hc1bc5cdf;

	logic [DATA_W-1:0] mem [0:4095];   // 4K words, low address bits only
	logic [31:0]       lfsr, step1, step2;
	logic [1:0]        draw, wait_cnt;
	logic              pending;        // Delay already drawn for this request
	logic              grant;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Two steps, one per delay bit
	assign step1 = lfsr_next(lfsr);
	assign step2 = lfsr_next(step1);
	assign draw  = {step1[0], step2[0]};

	// Acknowledge goes out on the next edge
	assign grant = req_i && !ack_o && (pending ? (wait_cnt == 2'd0) : (draw == 2'd0));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr     <= SEED;
			pending  <= 1'b0;
			wait_cnt <= 2'd0;
			ack_o    <= 1'b0;
			rdata_o  <= '0;
		end else if (ack_o) begin
			ack_o   <= 1'b0;         // One-cycle acknowledge
			pending <= 1'b0;
		end else if (req_i) begin
			if (!pending) begin
				lfsr    <= step2;
				pending <= 1'b1;
			end
			if (grant) begin
				ack_o   <= 1'b1;
				rdata_o <= mem[addr_i[11:0]];
			end else begin
				wait_cnt <= pending ? wait_cnt - 1'b1 : draw - 1'b1;
			end
		end
	end

	// Backdoor wins, bus writes land with the acknowledge
	always_ff @(posedge clk) begin
		if (pre_we_i)
			mem[pre_addr_i] <= pre_data_i;
		else if (grant && we_i)
			mem[addr_i[11:0]] <= wdata_i;
	end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
// DMA testbench with buffer model, memory model, stimulus,
// element stream checks, protocol assertions and cycle limit
`timescale 1ns/1ps
`default_nettype none

module tb_top
	import dma_bus_pkg::*;
	import dma_layer_pkg::*;
;

	localparam int RST_CYCLES = 16;
	localparam int PRELOAD    = 1024;
	localparam int ELEMS      = 2 * INIT_WORDS + 192 + 48 + 128 + 32; // Words plus tile elements
	localparam int TIMEOUT    = RST_CYCLES + PRELOAD + ELEMS * 6 + 600;

	logic              clk, rst, start, done, clr_cnt, quiet;
	logic [OP_W-1:0]   op_sel;
	logic [DIM_W-1:0]  org_x, org_y, nix, niy;
	logic [CH_W-1:0]   nif, nof;
	logic              stride;
	logic              ext_req, ext_we, ext_ack, buf_we;
	logic [ADDR_W-1:0] ext_addr, buf_addr;
	logic [DATA_W-1:0] ext_wdata, ext_rdata, buf_wdata, buf_rdata;
	logic              pre_we;
	logic [11:0]       pre_addr;
	logic [DATA_W-1:0] pre_data;
	logic [DATA_W-1:0] buf_mem [0:255];
	logic [31:0]       exp_addr [$];    // External address per element, tile order
	logic [31:0]       exp_buf [0:255]; // Expected buffer contents
	int                d_nix, d_niy, d_stride, d_nif, d_nof, d_ifm, d_ofm;
	int                wr_idx, done_cnt;
	int                ops_done = 0;
	int                cycles   = 0;

	clk_gen u_clk (.clk_o(clk));

	ext_mem_model u_mem (
		.clk(clk), .rst(rst), .req_i(ext_req), .we_i(ext_we), .addr_i(ext_addr),
		.wdata_i(ext_wdata), .pre_we_i(pre_we), .pre_addr_i(pre_addr),
		.pre_data_i(pre_data), .ack_o(ext_ack), .rdata_o(ext_rdata)
	);

	dma_top u_dut (
		.clk(clk), .rst(rst), .start_i(start), .op_i(op_sel),
		.origin_x_i(org_x), .origin_y_i(org_y), .ext_ack_i(ext_ack),
		.ext_rdata_i(ext_rdata), .buf_rdata_i(buf_rdata), .done_o(done),
		.ext_req_o(ext_req), .ext_we_o(ext_we), .ext_addr_o(ext_addr),
		.ext_wdata_o(ext_wdata), .buf_we_o(buf_we), .buf_addr_o(buf_addr),
		.buf_wdata_o(buf_wdata), .nix_o(nix), .niy_o(niy), .nif_o(nif),
		.nof_o(nof), .stride_o(stride)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got == want)
		else fail_run($sformatf("mismatch %s: got %h expected %h", name, got, want));
	endtask

	// Memory fill, every address bit matters
	function automatic logic [31:0] pattern_word(input logic [31:0] a);
		return (a * 32'h9e3779b1) ^ 32'h3c6ef372;
	endfunction

	// Buffer with one-cycle read latency
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			buf_rdata <= '0;
		end else begin
			if (buf_we)
				buf_mem[buf_addr[7:0]] <= buf_wdata;
			buf_rdata <= buf_mem[buf_addr[7:0]];
		end
	end

	// Element stream against the tile rule
	always @(posedge clk) begin
		if (clr_cnt) begin
			wr_idx <= 0;
		end else if (!rst && buf_we) begin
			assert (wr_idx < exp_addr.size()) else fail_run("fetch wrote past the end of the tile");
			expect_equal("buf_addr_o", buf_addr, wr_idx);
			expect_equal("buf_wdata_o", buf_wdata, pattern_word(exp_addr[wr_idx]));
			wr_idx <= wr_idx + 1;
		end else if (!rst && ext_req && ext_ack && ext_we) begin
			assert (wr_idx < exp_addr.size()) else fail_run("flush wrote past the end of the tile");
			expect_equal("ext_addr_o", ext_addr, exp_addr[wr_idx]);
			expect_equal("ext_wdata_o", ext_wdata, exp_buf[wr_idx]);
			wr_idx <= wr_idx + 1;
		end
	end

	always @(posedge clk or posedge rst) begin
		if (rst)
			done_cnt <= 0;
		else if (done)
			done_cnt <= done_cnt + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT)
			fail_run("run exceeded the cycle limit before all tests finished");
	end

	// Bus handshake rules
	assert property (@(posedge clk) disable iff (rst)
		ext_req && !ext_ack |=> ext_req && $stable(ext_addr) && $stable(ext_we)
			&& $stable(ext_wdata))
	else fail_run("request changed or dropped while waiting for acknowledge");

	assert property (@(posedge clk) disable iff (rst) ext_req && ext_ack |=> !ext_req)
	else fail_run("request still high in the cycle after an acknowledge");

	assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else fail_run("done pulse longer than one cycle");

	assert property (@(posedge clk) disable iff (rst) quiet |-> !ext_req && !done)
	else fail_run("ignored command produced a request or a done pulse");

	assert property (@(posedge clk) rst |-> !done && !ext_req && !ext_we && !buf_we)
	else fail_run("outputs active during reset");

	task automatic mem_backdoor_write(input int addr, input logic [31:0] data);
		@(posedge clk);
		pre_we   <= 1'b1;
		pre_addr <= 12'(addr);
		pre_data <= data;
	endtask

	task automatic write_descriptor(input int w, input int h, input int s, input int ci,
		input int co, input int ifm, input int ofm);
		layer_word_u word;
		d_nix    = w;
		d_niy    = h;
		d_stride = s;
		d_nif    = ci;
		d_nof    = co;
		d_ifm    = ifm;
		d_ofm    = ofm;
		word = '0;
		word.dims.nix    = DIM_W'(w);
		word.dims.niy    = DIM_W'(h);
		word.dims.stride = 1'(s);
		mem_backdoor_write(0, word.raw);
		word = '0;
		word.chan.nif = CH_W'(ci);
		word.chan.nof = CH_W'(co);
		mem_backdoor_write(1, word.raw);
		mem_backdoor_write(2, 32'(ifm));
		mem_backdoor_write(3, 32'(ofm));
		@(posedge clk);
		pre_we <= 1'b0;
	endtask

	// Expected addresses in x, y, channel order with edge clipping
	task automatic build_expected_tile(input bit fmo, input int ox, input int oy);
		int mw, mh, tw, th, cc, base;
		mw   = fmo ? (d_nix >> d_stride) : d_nix;
		mh   = fmo ? (d_niy >> d_stride) : d_niy;
		tw   = fmo ? (int'(TILE_X) >> d_stride) : int'(TILE_X);
		th   = fmo ? (int'(TILE_Y) >> d_stride) : int'(TILE_Y);
		cc   = fmo ? d_nof : d_nif;
		base = fmo ? d_ofm : d_ifm;
		exp_addr.delete();
		for (int c = 0; c < cc; c++)
			for (int y = oy; y < oy + th && y < mh; y++)
				for (int x = ox; x < ox + tw && x < mw; x++)
					exp_addr.push_back(32'(base + c * mw * mh + y * mw + x));
		if (!fmo)
			foreach (exp_addr[k])
				exp_buf[k] = pattern_word(exp_addr[k]); // Buffer after this fetch
	endtask

	task automatic pulse_start(input logic [OP_W-1:0] op, input int ox, input int oy);
		@(posedge clk);
		start   <= 1'b1;
		op_sel  <= op;
		org_x   <= DIM_W'(ox);
		org_y   <= DIM_W'(oy);
		clr_cnt <= 1'b1;
		@(posedge clk);
		start   <= 1'b0;
		clr_cnt <= 1'b0;
	endtask

	task automatic run_op(input logic [OP_W-1:0] op, input int ox, input int oy, input bit poke);
		pulse_start(op, ox, oy);
		if (poke) begin
			repeat (4) @(posedge clk);
			start  <= 1'b1;       // Stray init while busy
			op_sel <= OP_INIT;
			@(posedge clk);
			start  <= 1'b0;
		end
		do @(posedge clk); while (!done);
		@(posedge clk);
		ops_done++;
		expect_equal("done pulse count", done_cnt, ops_done);
		if (op != OP_INIT)
			expect_equal("element count", wr_idx, exp_addr.size());
	endtask

	task automatic check_layer_info(input int w, input int h, input int ci, input int co,
		input int s);
		expect_equal("nix_o", 32'(nix), w);
		expect_equal("niy_o", 32'(niy), h);
		expect_equal("nif_o", 32'(nif), ci);
		expect_equal("nof_o", 32'(nof), co);
		expect_equal("stride_o", 32'(stride), s);
	endtask

	task automatic check_flushed_words();
		foreach (exp_addr[k])
			expect_equal($sformatf("ext memory at %h", exp_addr[k]),
				u_mem.mem[exp_addr[k][11:0]], exp_buf[k]);
	endtask

	initial begin
		rst      = 1'b1;
		start    = 1'b0;
		op_sel   = '0;
		org_x    = '0;
		org_y    = '0;
		clr_cnt  = 1'b0;
		quiet    = 1'b0;
		pre_we   = 1'b0;
		pre_addr = '0;
		pre_data = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		check_layer_info(0, 0, 0, 0, 0);
		for (int i = 0; i < PRELOAD; i++)
			mem_backdoor_write(i, pattern_word(i));
		write_descriptor(20, 12, 0, 3, 2, 'h100, 'h800);
		run_op(OP_INIT, 0, 0, 1'b0);
		check_layer_info(20, 12, 3, 2, 0);
		// Unknown opcode is dropped
		quiet <= 1'b1;
		pulse_start(3'd5, 0, 0);
		repeat (10) @(posedge clk);
		quiet <= 1'b0;
		expect_equal("done pulse count", done_cnt, ops_done);
		build_expected_tile(1'b0, 4, 2);     // Full 8x8 tile, 3 channels
		run_op(OP_FMI, 4, 2, 1'b1);
		check_layer_info(20, 12, 3, 2, 0);
		build_expected_tile(1'b0, 16, 8);    // Clipped at right and bottom
		run_op(OP_FMI, 16, 8, 1'b0);
		build_expected_tile(1'b1, 4, 4);
		run_op(OP_FMO, 4, 4, 1'b0);
		check_flushed_words();
		// Stride 2 halves the output map and tile
		write_descriptor(20, 12, 1, 3, 2, 'h100, 'h800);
		run_op(OP_INIT, 0, 0, 1'b0);
		check_layer_info(20, 12, 3, 2, 1);
		build_expected_tile(1'b1, 6, 2);
		run_op(OP_FMO, 6, 2, 1'b1);
		check_flushed_words();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/dma_ctrl.sv ====
// DMA operation FSM
// external request/acknowledge sequencing and the data word register
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl
	import dma_bus_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start_i,
	input  logic [OP_W-1:0]               op_i,
	input  logic                          ext_ack_i,
	input  logic [DATA_W-1:0]             ext_rdata_i,
	input  logic [DATA_W-1:0]             buf_rdata_i,
	input  logic [$clog2(INIT_WORDS)-1:0] word_idx_i,   // Descriptor word being read
	input  logic                          init_last_i,
	input  logic [ADDR_W-1:0]             walk_addr_i,
	input  logic                          walk_last_i,
	output logic                          done_o,
	output logic                          ext_req_o,
	output logic                          ext_we_o,
	output logic [ADDR_W-1:0]             ext_addr_o,
	output logic [DATA_W-1:0]             ext_wdata_o,
	output logic                          buf_we_o,
	output logic [DATA_W-1:0]             buf_wdata_o,
	output logic                          init_start_o, // Clears word index
	output logic                          capture_o,    // Descriptor word valid
	output logic                          walk_load_o,
	output logic                          walk_fmo_o,
	output logic                          walk_step_o
);

	enum logic [2:0] {
		S_IDLE,
		S_INIT_RD,
		S_FMI_RD,
		S_FMI_WR,
		S_FMO_LD,  // Buffer read in flight
		S_FMO_WR,
		S_DONE
	} state;

	logic [DATA_W-1:0] data_q; // Element in transit
	logic              acked;

	assign acked = ext_req_o && ext_ack_i;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= S_IDLE;
			ext_req_o <= 1'b0;
			ext_we_o  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_i) begin
						case (op_i)
							OP_INIT: begin
								state     <= S_INIT_RD;
								ext_req_o <= 1'b1;
								ext_we_o  <= 1'b0;
							end
							OP_FMI: begin
								state     <= S_FMI_RD;
								ext_req_o <= 1'b1;
								ext_we_o  <= 1'b0;
							end
							OP_FMO:  state <= S_FMO_LD;
							default: state <= S_IDLE; // Unknown op dropped
						endcase
					end
				end
				S_INIT_RD: begin
					if (acked) begin
						ext_req_o <= 1'b0;
						if (init_last_i)
							state <= S_DONE;
					end else if (!ext_req_o) begin
						ext_req_o <= 1'b1; // Next word, one idle cycle after ack
					end
				end
				S_FMI_RD: begin
					if (acked) begin
						ext_req_o <= 1'b0;
						state     <= S_FMI_WR;
					end
				end
				S_FMI_WR: begin
					if (walk_last_i) begin
						state <= S_DONE;
					end else begin
						state     <= S_FMI_RD;
						ext_req_o <= 1'b1;
					end
				end
				S_FMO_LD: state <= S_FMO_WR;
				S_FMO_WR: begin
					if (acked) begin
						ext_req_o <= 1'b0;
						ext_we_o  <= 1'b0;
						state     <= walk_last_i ? S_DONE : S_FMO_LD;
					end else if (!ext_req_o) begin
						// First cycle here, buffer data arrives now
						ext_req_o <= 1'b1;
						ext_we_o  <= 1'b1;
					end
				end
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Read data from either side lands in one register
	always_ff @(posedge clk) begin
		if (state == S_FMI_RD && acked)
			data_q <= ext_rdata_i;
		else if (state == S_FMO_WR && !ext_req_o)
			data_q <= buf_rdata_i;
	end

	assign done_o      = (state == S_DONE);
	assign buf_we_o    = (state == S_FMI_WR);
	assign ext_wdata_o = data_q;
	assign buf_wdata_o = data_q;

	// Word index drives the address only during init
	assign ext_addr_o = (state == S_INIT_RD) ? ADDR_W'(word_idx_i) : walk_addr_i;

	assign init_start_o = (state == S_IDLE) && start_i && (op_i == OP_INIT);
	assign capture_o    = (state == S_INIT_RD) && acked;
	assign walk_load_o  = (state == S_IDLE) && start_i && (op_i == OP_FMI || op_i == OP_FMO);
	assign walk_fmo_o   = (op_i == OP_FMO);
	assign walk_step_o  = (state == S_FMI_WR) || (state == S_FMO_WR && acked);

endmodule

`default_nettype wire

// ==== src/dma_top.sv ====
// DMA top level
// wires the controller, the layer registers and the tile walker
`timescale 1ns/1ps
`default_nettype none

module dma_top
	import dma_bus_pkg::*;
	import dma_layer_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start_i,
	input  logic [OP_W-1:0]   op_i,
	input  logic [DIM_W-1:0]  origin_x_i,  // Tile origin in the map
	input  logic [DIM_W-1:0]  origin_y_i,
	input  logic              ext_ack_i,
	input  logic [DATA_W-1:0] ext_rdata_i,
	input  logic [DATA_W-1:0] buf_rdata_i,
	output logic              done_o,
	output logic              ext_req_o,
	output logic              ext_we_o,
	output logic [ADDR_W-1:0] ext_addr_o,
	output logic [DATA_W-1:0] ext_wdata_o,
	output logic              buf_we_o,
	output logic [ADDR_W-1:0] buf_addr_o,
	output logic [DATA_W-1:0] buf_wdata_o,
	output logic [DIM_W-1:0]  nix_o,       // Layer info for the main controller
	output logic [DIM_W-1:0]  niy_o,
	output logic [CH_W-1:0]   nif_o,
	output logic [CH_W-1:0]   nof_o,
	output logic              stride_o
);

	logic                          init_start, capture, init_last;
	logic [$clog2(INIT_WORDS)-1:0] word_idx;
	logic                          walk_load, walk_fmo, walk_step, walk_last;
	logic [ADDR_W-1:0]             walk_addr;
	logic [DIM_W-1:0]              nox, noy;
	logic [ADDR_W-1:0]             ifm_base, ofm_base;

	// Op sequencing and bus handshake
	dma_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.op_i         (op_i),
		.ext_ack_i    (ext_ack_i),
		.ext_rdata_i  (ext_rdata_i),
		.buf_rdata_i  (buf_rdata_i),
		.word_idx_i   (word_idx),
		.init_last_i  (init_last),
		.walk_addr_i  (walk_addr),
		.walk_last_i  (walk_last),
		.done_o       (done_o),
		.ext_req_o    (ext_req_o),
		.ext_we_o     (ext_we_o),
		.ext_addr_o   (ext_addr_o),
		.ext_wdata_o  (ext_wdata_o),
		.buf_we_o     (buf_we_o),
		.buf_wdata_o  (buf_wdata_o),
		.init_start_o (init_start),
		.capture_o    (capture),
		.walk_load_o  (walk_load),
		.walk_fmo_o   (walk_fmo),
		.walk_step_o  (walk_step)
	);

	// Descriptor words come straight off the read bus
	layer_regs u_layer (
		.clk          (clk),
		.rst          (rst),
		.init_start_i (init_start),
		.capture_i    (capture),
		.data_i       (ext_rdata_i),
		.word_idx_o   (word_idx),
		.init_last_o  (init_last),
		.nix_o        (nix_o),
		.niy_o        (niy_o),
		.nif_o        (nif_o),
		.nof_o        (nof_o),
		.stride_o     (stride_o),
		.nox_o        (nox),
		.noy_o        (noy),
		.ifm_base_o   (ifm_base),
		.ofm_base_o   (ofm_base)
	);

	tile_walker u_walker (
		.clk        (clk),
		.rst        (rst),
		.load_i     (walk_load),
		.fmo_i      (walk_fmo),
		.step_i     (walk_step),
		.origin_x_i (origin_x_i),
		.origin_y_i (origin_y_i),
		.nix_i      (nix_o),
		.niy_i      (niy_o),
		.nox_i      (nox),
		.noy_i      (noy),
		.nif_i      (nif_o),
		.nof_i      (nof_o),
		.stride_i   (stride_o),
		.ifm_base_i (ifm_base),
		.ofm_base_i (ofm_base),
		.ext_addr_o (walk_addr),
		.buf_addr_o (buf_addr_o),
		.last_o     (walk_last)
	);

endmodule

`default_nettype wire

// ==== src/layer_regs.sv ====
// Layer descriptor registers with the word index
// and the output dimensions derived from the stride
`timescale 1ns/1ps
`default_nettype none

module layer_regs
	import dma_bus_pkg::*;
	import dma_layer_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          init_start_i,
	input  logic                          capture_i,
	input  logic [DATA_W-1:0]             data_i,
	output logic [$clog2(INIT_WORDS)-1:0] word_idx_o,
	output logic                          init_last_o,
	output logic [DIM_W-1:0]              nix_o,
	output logic [DIM_W-1:0]              niy_o,
	output logic [CH_W-1:0]               nif_o,
	output logic [CH_W-1:0]               nof_o,
	output logic                          stride_o,
	output logic [DIM_W-1:0]              nox_o,
	output logic [DIM_W-1:0]              noy_o,
	output logic [ADDR_W-1:0]             ifm_base_o,
	output logic [ADDR_W-1:0]             ofm_base_o
);

	layer_word_u word;

	assign word = data_i;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_idx_o <= '0;
			nix_o      <= '0;
			niy_o      <= '0;
			nif_o      <= '0;
			nof_o      <= '0;
			stride_o   <= 1'b0;
			ifm_base_o <= '0;
			ofm_base_o <= '0;
		end else if (init_start_i) begin
			word_idx_o <= '0;
		end else if (capture_i) begin
			word_idx_o <= word_idx_o + 1'b1;
			// Decode by word position
			case (word_idx_o)
				2'd0: begin
					nix_o    <= word.dims.nix;
					niy_o    <= word.dims.niy;
					stride_o <= word.dims.stride;
				end
				2'd1: begin
					nif_o <= word.chan.nif;
					nof_o <= word.chan.nof;
				end
				2'd2:    ifm_base_o <= word.raw;
				default: ofm_base_o <= word.raw;
			endcase
		end
	end

	assign init_last_o = (word_idx_o == ($clog2(INIT_WORDS))'(INIT_WORDS - 1));

	// Stride 2 halves the output map
	assign nox_o = nix_o >> stride_o;
	assign noy_o = niy_o >> stride_o;

endmodule

`default_nettype wire

// ==== walker/tile_walker.sv ====
// Tile walker over x, y and channel with edge clipping
// generates external and buffer addresses without loop multipliers
`timescale 1ns/1ps
`default_nettype none

module tile_walker
	import dma_bus_pkg::*;
	import dma_layer_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              load_i,     // Start of fetch or flush
	input  logic              fmo_i,      // Flush mode, output map geometry
	input  logic              step_i,
	input  logic [DIM_W-1:0]  origin_x_i,
	input  logic [DIM_W-1:0]  origin_y_i,
	input  logic [DIM_W-1:0]  nix_i,
	input  logic [DIM_W-1:0]  niy_i,
	input  logic [DIM_W-1:0]  nox_i,
	input  logic [DIM_W-1:0]  noy_i,
	input  logic [CH_W-1:0]   nif_i,
	input  logic [CH_W-1:0]   nof_i,
	input  logic              stride_i,
	input  logic [ADDR_W-1:0] ifm_base_i,
	input  logic [ADDR_W-1:0] ofm_base_i,
	output logic [ADDR_W-1:0] ext_addr_o,
	output logic [ADDR_W-1:0] buf_addr_o,
	output logic              last_o
);

	logic                 fmo_q, mode;
	logic [DIM_W-1:0]     ox_q, oy_q, x_q, y_q;   // Origin and current position
	logic [CH_W-1:0]      ch_q;
	logic [ADDR_W-1:0]    row_q;                   // Address of (ch, y, 0)
	logic [ADDR_W-1:0]    plane_q;                 // Row address of first tile row
	logic [ADDR_W-1:0]    plane_size_q;
	logic [DIM_W-1:0]     map_w, map_h, tile_w, tile_h;
	logic [CH_W-1:0]      ch_cnt;
	logic [ADDR_W-1:0]    base;
	logic [2*DIM_W-1:0]   row_off, plane_size;
	logic                 x_end, y_end, ch_end;

	// Geometry follows the incoming mode during load
	assign mode   = load_i ? fmo_i : fmo_q;
	assign map_w  = mode ? nox_i : nix_i;
	assign map_h  = mode ? noy_i : niy_i;
	assign tile_w = mode ? (TILE_X >> stride_i) : TILE_X;
	assign tile_h = mode ? (TILE_Y >> stride_i) : TILE_Y;
	assign ch_cnt = mode ? nof_i : nif_i;
	assign base   = mode ? ofm_base_i : ifm_base_i;

	// Only used at load
	assign row_off    = origin_y_i * map_w;
	assign plane_size = map_w * map_h;

	// Row or column ends at tile size or map edge
	assign x_end  = (x_q - ox_q == tile_w - 1'b1) || (x_q == map_w - 1'b1);
	assign y_end  = (y_q - oy_q == tile_h - 1'b1) || (y_q == map_h - 1'b1);
	assign ch_end = (ch_q == ch_cnt - 1'b1);
	assign last_o = x_end && y_end && ch_end;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fmo_q        <= 1'b0;
			ox_q         <= '0;
			oy_q         <= '0;
			x_q          <= '0;
			y_q          <= '0;
			ch_q         <= '0;
			row_q        <= '0;
			plane_q      <= '0;
			plane_size_q <= '0;
			buf_addr_o   <= '0;
		end else if (load_i) begin
			fmo_q        <= fmo_i;
			ox_q         <= origin_x_i;
			oy_q         <= origin_y_i;
			x_q          <= origin_x_i;
			y_q          <= origin_y_i;
			ch_q         <= '0;
			row_q        <= base + ADDR_W'(row_off);
			plane_q      <= base + ADDR_W'(row_off);
			plane_size_q <= ADDR_W'(plane_size);
			buf_addr_o   <= '0;              // Buffer fills from 0 each op
		end else if (step_i) begin
			buf_addr_o <= buf_addr_o + 1'b1;
			if (!x_end) begin
				x_q <= x_q + 1'b1;
			end else begin
				x_q <= ox_q;                 // Wrap to tile left edge
				if (!y_end) begin
					y_q   <= y_q + 1'b1;
					row_q <= row_q + ADDR_W'(map_w);
				end else begin
					// Next channel plane
					y_q     <= oy_q;
					ch_q    <= ch_q + 1'b1;
					plane_q <= plane_q + plane_size_q;
					row_q   <= plane_q + plane_size_q;
				end
			end
		end
	end

	assign ext_addr_o = row_q + ADDR_W'(x_q);

endmodule

`default_nettype wire
